// ==== Makefile ====
# Verilator build of the PLIC testbench, run from the project root.

SIM := obj_dir/plic_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f \
		--top-module plic_tb -o plic_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== hw/lsioc_skid_buffer.sv ====
// ######################################
// Two entries, in-order drain.
// consume_i only while out_vld_o is high.
// ######################################
`timescale 1ns/1ps
`default_nettype none

module lsioc_skid_buffer #(
    parameter int DATA_W = 32
) (
    input  wire               lsioc_clk_i,
    input  wire               rst_n_i,
    input  wire               in_vld_i,
    input  wire  [DATA_W-1:0] in_data_i,
    input  wire               consume_i,
    output logic              in_busy_o,
    output logic              out_vld_o,
    output logic [DATA_W-1:0] out_data_o
);

    logic              main_vld;
    logic              spare_vld;
    logic [DATA_W-1:0] main_data;
    logic [DATA_W-1:0] spare_data;
    logic              push;

    // Spare only fills behind a full main.
    assign push = in_vld_i && !spare_vld;

    always_ff @(posedge lsioc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            main_vld  <= 1'b0;
            spare_vld <= 1'b0;
        end else if (spare_vld) begin
            if (consume_i) begin
                spare_vld <= 1'b0;  // Spare moves up.
            end
        end else if (main_vld) begin
            if (push && !consume_i) begin
                spare_vld <= 1'b1;
            end else if (!push && consume_i) begin
                main_vld <= 1'b0;
            end
        end else if (push) begin
            main_vld <= 1'b1;
        end
    end

    always_ff @(posedge lsioc_clk_i) begin
        if (spare_vld) begin
            if (consume_i) begin
                main_data <= spare_data;
            end
        end else if (push) begin
            if (!main_vld || consume_i) begin
                main_data <= in_data_i;
            end else begin
                spare_data <= in_data_i;
            end
        end
    end

    assign in_busy_o  = spare_vld;  // Both entries full.
    assign out_vld_o  = main_vld;
    assign out_data_o = main_data;

endmodule

`default_nettype wire

// ==== hw/plic_pkg.sv ====
// ######################################
// Fixed register map, one-bit priorities.
// Source 0 is reserved and never pending.
// ######################################
`default_nettype none

package plic_pkg;

    // Bus field widths.
    typedef logic [21:0] lsioc_addr_t;
    typedef logic [31:0] lsioc_data_t;
    typedef logic [2:0]  lsioc_opc_t;
    typedef logic [1:0]  lsioc_err_t;

    typedef logic [7:0] reg_val_t;   // Internal register width.
    typedef logic [2:0] claim_id_t;  // Zero means no interrupt.
    typedef logic [7:0] src_vec_t;   // Bit n is source n.

    localparam lsioc_opc_t OPC_READ    = 3'b000;
    localparam lsioc_opc_t OPC_WRITE   = 3'b001;
    localparam lsioc_opc_t OPC_AMOAND  = 3'b100;
    localparam lsioc_opc_t OPC_AMOOR   = 3'b101;
    localparam lsioc_opc_t OPC_AMOSWAP = 3'b110;
    localparam lsioc_opc_t OPC_AMOXOR  = 3'b111;

    localparam lsioc_err_t RESP_OK = 2'b00;

    localparam int NUM_CONTEXTS = 4;
    localparam int REQ_W        = 57;  // Address, data, opcode.

    // Priority of source n sits at ADDR_PRIO_BASE + 4*n.
    localparam lsioc_addr_t ADDR_PRIO_BASE     = 22'h000000;
    localparam lsioc_addr_t ADDR_PENDING       = 22'h001000;
    localparam lsioc_addr_t ADDR_ENABLE_BASE   = 22'h002000;
    localparam lsioc_addr_t ADDR_ENABLE_STRIDE = 22'h000080;
    localparam lsioc_addr_t ADDR_THRESH_BASE   = 22'h200000;
    localparam lsioc_addr_t ADDR_THRESH_STRIDE = 22'h001000;
    localparam lsioc_addr_t ADDR_CLAIM_OFS     = 22'h000004;  // Past threshold.

    // Interrupt targets.
    typedef enum logic [1:0] {
        CTX_HART0_M = 2'd0,
        CTX_HART0_S = 2'd1,
        CTX_HART1_M = 2'd2,
        CTX_HART1_S = 2'd3
    } ctx_t;

endpackage

`default_nettype wire

// ==== hw/plic_reg_stage.sv ====
// ######################################
// Only the low data byte is stored.
// Responses always carry RESP_OK.
// ######################################
`timescale 1ns/1ps
`default_nettype none

module plic_reg_stage (
    input  wire                                 lsioc_clk_i,
    input  wire                                 rst_n_i,
    input  wire                                 req_vld_i,
    input  wire  [plic_pkg::REQ_W-1:0]          req_data_i,
    input  wire  plic_pkg::src_vec_t            pending_i,
    input  wire                                 tx_busy_i,
    input  wire  plic_pkg::claim_id_t           claim_id_i [plic_pkg::NUM_CONTEXTS],
    output logic                                consume_o,
    output logic                                tx_vld_o,
    output plic_pkg::lsioc_data_t               tx_data_o,
    output plic_pkg::lsioc_err_t                tx_err_o,
    output plic_pkg::src_vec_t                  prio_o,
    output plic_pkg::src_vec_t                  enable_o [plic_pkg::NUM_CONTEXTS],
    output logic [plic_pkg::NUM_CONTEXTS-1:0]   threshold_o,
    output plic_pkg::src_vec_t                  claimed_o [plic_pkg::NUM_CONTEXTS]
);

    plic_pkg::lsioc_addr_t req_addr;
    plic_pkg::lsioc_data_t req_wdata;
    plic_pkg::lsioc_opc_t  req_opc;

    plic_pkg::src_vec_t                prio_q;
    plic_pkg::src_vec_t                enable_q [plic_pkg::NUM_CONTEXTS];
    logic [plic_pkg::NUM_CONTEXTS-1:0] thresh_q;
    plic_pkg::src_vec_t                claimed_q [plic_pkg::NUM_CONTEXTS];

    plic_pkg::ctx_t      en_ctx;
    plic_pkg::ctx_t      th_ctx;
    plic_pkg::claim_id_t prio_idx;
    logic                prio_sel;
    logic                en_sel;
    logic                th_sel;
    logic                cl_sel;

    plic_pkg::reg_val_t rd_val;
    plic_pkg::reg_val_t wr_val;
    logic               wr_en;
    plic_pkg::src_vec_t claim_oh;
    plic_pkg::src_vec_t done_oh;

    assign {req_addr, req_wdata, req_opc} = req_data_i;
    assign consume_o = req_vld_i && !tx_busy_i;

    // Context index comes from the stride bits, then the full address is checked.
    assign en_ctx   = plic_pkg::ctx_t'(req_addr[8:7]);
    assign th_ctx   = plic_pkg::ctx_t'(req_addr[13:12]);
    assign prio_idx = req_addr[4:2];

    assign prio_sel = ({req_addr[21:5], 3'b000, req_addr[1:0]} == plic_pkg::ADDR_PRIO_BASE)
                      && (prio_idx != 3'd0);
    assign en_sel   = req_addr == plic_pkg::ADDR_ENABLE_BASE
                      + plic_pkg::ADDR_ENABLE_STRIDE * plic_pkg::lsioc_addr_t'(en_ctx);
    assign th_sel   = req_addr == plic_pkg::ADDR_THRESH_BASE
                      + plic_pkg::ADDR_THRESH_STRIDE * plic_pkg::lsioc_addr_t'(th_ctx);
    assign cl_sel   = req_addr == plic_pkg::ADDR_THRESH_BASE + plic_pkg::ADDR_CLAIM_OFS
                      + plic_pkg::ADDR_THRESH_STRIDE * plic_pkg::lsioc_addr_t'(th_ctx);

    always_comb begin
        rd_val = '0;  // Unmapped reads as zero.
        if (prio_sel) begin
            rd_val = {7'b0, prio_q[prio_idx]};
        end else if (req_addr == plic_pkg::ADDR_PENDING) begin
            rd_val = pending_i;
        end else if (en_sel) begin
            rd_val = enable_q[en_ctx];
        end else if (th_sel) begin
            rd_val = {7'b0, thresh_q[th_ctx]};
        end else if (cl_sel) begin
            rd_val = {5'b0, claim_id_i[th_ctx]};
        end
    end

    always_comb begin
        wr_val = req_wdata[7:0];
        wr_en  = 1'b1;
        case (req_opc)
            plic_pkg::OPC_READ:    wr_en = 1'b0;
            plic_pkg::OPC_WRITE,
            plic_pkg::OPC_AMOSWAP: wr_val = req_wdata[7:0];
            plic_pkg::OPC_AMOAND:  wr_val = rd_val & req_wdata[7:0];
            plic_pkg::OPC_AMOOR:   wr_val = rd_val | req_wdata[7:0];
            plic_pkg::OPC_AMOXOR:  wr_val = rd_val ^ req_wdata[7:0];
            default:               wr_en = 1'b0;
        endcase
    end

    // One-hot of the ID being claimed and of the ID being completed.
    assign claim_oh = plic_pkg::src_vec_t'(1) << claim_id_i[th_ctx];
    assign done_oh  = (plic_pkg::src_vec_t'(1) << wr_val[2:0]) & 8'hFE;

    always_ff @(posedge lsioc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q    <= '0;
            enable_q  <= '{default: '0};
            thresh_q  <= '0;
            claimed_q <= '{default: '0};
        end else if (consume_o) begin
            if (wr_en) begin
                if (prio_sel) begin
                    prio_q[prio_idx] <= wr_val[0];
                end
                if (en_sel) begin
                    enable_q[en_ctx] <= wr_val & 8'hFE;  // No source 0.
                end
                if (th_sel) begin
                    thresh_q[th_ctx] <= wr_val[0];
                end
                if (cl_sel) begin
                    // Clears nothing unless the ID was claimed.
                    claimed_q[th_ctx] <= claimed_q[th_ctx] & ~done_oh;
                end
            end else if (cl_sel) begin
                claimed_q[th_ctx] <= claimed_q[th_ctx] | (claim_oh & 8'hFE);
            end
        end
    end

    always_ff @(posedge lsioc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_vld_o  <= 1'b0;
            tx_data_o <= '0;
            tx_err_o  <= plic_pkg::RESP_OK;
        end else if (!tx_busy_i) begin
            tx_vld_o <= req_vld_i;
            if (req_vld_i) begin
                tx_data_o <= {24'b0, rd_val};  // Old value.
                tx_err_o  <= plic_pkg::RESP_OK;
            end
        end
    end

    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign threshold_o = thresh_q;
    assign claimed_o   = claimed_q;

endmodule

`default_nettype wire

// ==== hw/plic_target_arbiter.sv ====
// ######################################
// Highest ID wins; eip_o lags one cycle.
// ######################################
`timescale 1ns/1ps
`default_nettype none

module plic_target_arbiter (
    input  wire                         lsioc_clk_i,
    input  wire                         rst_n_i,
    input  wire  plic_pkg::src_vec_t    pending_i,
    input  wire  plic_pkg::src_vec_t    prio_i,
    input  wire  plic_pkg::src_vec_t    enable_i,
    input  wire  plic_pkg::src_vec_t    claimed_i,
    input  wire                         threshold_i,
    output plic_pkg::claim_id_t         claim_id_o,
    output logic                        eip_o
);

    plic_pkg::src_vec_t eligible;
    logic               above_thresh;

    // Pending, prioritized, enabled and not yet claimed here.
    assign eligible = pending_i & prio_i & enable_i & ~claimed_i & 8'hFE;

    // Priority encoder, upper sources override lower.
    always_comb begin
        claim_id_o = '0;
        for (int i = 1; i < 8; i++) begin
            if (eligible[i]) begin
                claim_id_o = plic_pkg::claim_id_t'(i);
            end
        end
    end

    // All eligible sources have priority 1, so only threshold 0 lets them through.
    assign above_thresh = 1'b1 > threshold_i;

    always_ff @(posedge lsioc_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            eip_o <= 1'b0;
        end else begin
            eip_o <= (|eligible) && above_thresh;
        end
    end

endmodule

`default_nettype wire

// ==== hw/plic_top.sv ====
// ######################################
// int_i must be synchronous and level.
// eip_o bit c belongs to context c.
// ######################################
`timescale 1ns/1ps
`default_nettype none

module plic_top (
    input  wire                                 lsioc_clk_i,
    input  wire                                 rst_n_i,

    input  wire                                 lsioc_rx_vld_i,
    input  wire  plic_pkg::lsioc_addr_t         lsioc_rx_addr_i,
    input  wire  plic_pkg::lsioc_data_t         lsioc_rx_data_i,
    input  wire  plic_pkg::lsioc_opc_t          lsioc_rx_opc_i,
    output wire                                 lsioc_rx_busy_o,

    output wire                                 lsioc_tx_vld_o,
    output wire  plic_pkg::lsioc_data_t         lsioc_tx_data_o,
    output wire  plic_pkg::lsioc_err_t          lsioc_tx_err_o,
    input  wire                                 lsioc_tx_busy_i,

    input  wire  [6:0]                          int_i,
    output wire  [plic_pkg::NUM_CONTEXTS-1:0]   eip_o
);

    wire                               req_vld;
    wire [plic_pkg::REQ_W-1:0]         req_data;
    wire                               consume;
    wire plic_pkg::src_vec_t           pending;
    wire plic_pkg::src_vec_t           prio;
    wire plic_pkg::src_vec_t           enable [plic_pkg::NUM_CONTEXTS];
    wire [plic_pkg::NUM_CONTEXTS-1:0]  threshold;
    wire plic_pkg::src_vec_t           claimed [plic_pkg::NUM_CONTEXTS];
    wire plic_pkg::claim_id_t          claim_id [plic_pkg::NUM_CONTEXTS];

    assign pending = {int_i, 1'b0};  // Source 0 never pends.

    lsioc_skid_buffer #(
        .DATA_W (plic_pkg::REQ_W)
    ) u_skid (
        .lsioc_clk_i (lsioc_clk_i),
        .rst_n_i     (rst_n_i),
        .in_vld_i    (lsioc_rx_vld_i),
        .in_data_i   ({lsioc_rx_addr_i, lsioc_rx_data_i, lsioc_rx_opc_i}),
        .consume_i   (consume),
        .in_busy_o   (lsioc_rx_busy_o),
        .out_vld_o   (req_vld),
        .out_data_o  (req_data)
    );

    plic_reg_stage u_regs (
        .lsioc_clk_i (lsioc_clk_i),
        .rst_n_i     (rst_n_i),
        .req_vld_i   (req_vld),
        .req_data_i  (req_data),
        .pending_i   (pending),
        .tx_busy_i   (lsioc_tx_busy_i),
        .claim_id_i  (claim_id),
        .consume_o   (consume),
        .tx_vld_o    (lsioc_tx_vld_o),
        .tx_data_o   (lsioc_tx_data_o),
        .tx_err_o    (lsioc_tx_err_o),
        .prio_o      (prio),
        .enable_o    (enable),
        .threshold_o (threshold),
        .claimed_o   (claimed)
    );

    for (genvar c = 0; c < plic_pkg::NUM_CONTEXTS; c++) begin : g_ctx
        plic_target_arbiter u_arb (
            .lsioc_clk_i (lsioc_clk_i),
            .rst_n_i     (rst_n_i),
            .pending_i   (pending),
            .prio_i      (prio),
            .enable_i    (enable[c]),
            .claimed_i   (claimed[c]),
            .threshold_i (threshold[c]),
            .claim_id_o  (claim_id[c]),
            .eip_o       (eip_o[c])
        );
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/plic_pkg.sv
hw/lsioc_skid_buffer.sv
hw/plic_target_arbiter.sv
hw/plic_reg_stage.sv
hw/plic_top.sv
verif/plic_tb.sv

// ==== verif/plic_tb.sv ====
// ######################################
// Reads verif/plic_testdata.hex, run from the project root.
// One request in flight at a time, tx busy is random.
// ######################################
`timescale 1ns/1ps
`default_nettype none

module plic_tb;

    localparam int MAX_TRANS  = 64;
    localparam int COLS       = 6;
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] END_MARK = 32'h0000000f;

    logic                        clk;
    logic                        rst_n;
    logic                        rx_vld;
    plic_pkg::lsioc_addr_t       rx_addr;
    plic_pkg::lsioc_data_t       rx_data;
    plic_pkg::lsioc_opc_t        rx_opc;
    wire                         rx_busy;
    wire                         tx_vld;
    wire plic_pkg::lsioc_data_t  tx_data;
    wire plic_pkg::lsioc_err_t   tx_err;
    logic                        tx_busy;
    logic [6:0]                  int_drv;
    wire  [3:0]                  eip;

    logic [31:0]                 vec_mem [0:MAX_TRANS*COLS-1];
    logic [31:0]                 lcg_state;
    int                          error_count;
    int                          hold_errors;
    int                          resp_count;
    int                          n_trans;
    logic                        hold_seen;
    plic_pkg::lsioc_data_t       held_data;

    plic_top UUT (
        .lsioc_clk_i     (clk),
        .rst_n_i         (rst_n),
        .lsioc_rx_vld_i  (rx_vld),
        .lsioc_rx_addr_i (rx_addr),
        .lsioc_rx_data_i (rx_data),
        .lsioc_rx_opc_i  (rx_opc),
        .lsioc_rx_busy_o (rx_busy),
        .lsioc_tx_vld_o  (tx_vld),
        .lsioc_tx_data_o (tx_data),
        .lsioc_tx_err_o  (tx_err),
        .lsioc_tx_busy_i (tx_busy),
        .int_i           (int_drv),
        .eip_o           (eip)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Random back-pressure on the response channel.
    initial begin
        tx_busy   = 1'b0;
        lcg_state = 32'd71;
        forever begin
            @(posedge clk);
            lcg_state = lcg_next(lcg_state);
            tx_busy <= lcg_state[16];
        end
    end

    // Held responses must stay put, and every handshake is counted.
    always @(negedge clk) begin
        if (!rst_n) begin
            hold_seen   = 1'b0;
            held_data   = '0;
            hold_errors = 0;
            resp_count  = 0;
        end else begin
            if (hold_seen && !tx_vld) begin
                $display("Response was dropped while tx busy was high");
                hold_errors++;
            end else if (hold_seen && tx_data !== held_data) begin
                $display("FAILED lsioc_tx_data_o: got %h, expected %h while held",
                         tx_data, held_data);
                hold_errors++;
            end
            if (tx_vld && !tx_busy) begin
                resp_count++;
            end
            hold_seen = tx_vld && tx_busy;
            held_data = tx_data;
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic run_transaction(input int idx);
        plic_pkg::lsioc_opc_t  opc;
        plic_pkg::lsioc_addr_t addr;
        plic_pkg::lsioc_data_t wdata;
        logic [6:0]            int_val;
        plic_pkg::lsioc_data_t exp_data;
        logic [3:0]            exp_eip;
        int                    cycles;
        opc      = vec_mem[COLS*idx][2:0];
        addr     = vec_mem[COLS*idx+1][21:0];
        wdata    = vec_mem[COLS*idx+2];
        int_val  = vec_mem[COLS*idx+3][6:0];
        exp_data = vec_mem[COLS*idx+4];
        exp_eip  = vec_mem[COLS*idx+5][3:0];

        @(posedge clk);
        int_drv <= int_val;  // Sources settle before the request.
        @(posedge clk);
        rx_vld  <= 1'b1;
        rx_addr <= addr;
        rx_data <= wdata;
        rx_opc  <= opc;

        cycles = 0;
        @(negedge clk);
        while (rx_busy) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_timeout("request was never accepted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        rx_vld <= 1'b0;

        cycles = 0;
        @(negedge clk);
        while (!(tx_vld && !tx_busy)) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_timeout("no response arrived");
            end
            @(negedge clk);
        end

        // Handshake completes at the coming edge.
        if (tx_data !== exp_data) begin
            $display("FAILED lsioc_tx_data_o: got %h, expected %h (transaction %0d)",
                     tx_data, exp_data, idx);
            error_count++;
        end
        if (tx_err !== plic_pkg::RESP_OK) begin
            $display("FAILED lsioc_tx_err_o: got %h, expected %h (transaction %0d)",
                     tx_err, plic_pkg::RESP_OK, idx);
            error_count++;
        end

        @(posedge clk);
        @(negedge clk);
        if (eip !== exp_eip) begin
            $display("FAILED eip_o: got %h, expected %h (transaction %0d)",
                     eip, exp_eip, idx);
            error_count++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        rx_vld      = 1'b0;
        rx_addr     = '0;
        rx_data     = '0;
        rx_opc      = '0;
        int_drv     = '0;
        error_count = 0;
        n_trans     = 0;
        $readmemh("verif/plic_testdata.hex", vec_mem);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        if (tx_vld !== 1'b0) begin
            $display("FAILED lsioc_tx_vld_o: got %h, expected %h after reset", tx_vld, 1'b0);
            error_count++;
        end
        if (rx_busy !== 1'b0) begin
            $display("FAILED lsioc_rx_busy_o: got %h, expected %h after reset", rx_busy, 1'b0);
            error_count++;
        end
        if (eip !== 4'h0) begin
            $display("FAILED eip_o: got %h, expected %h after reset", eip, 4'h0);
            error_count++;
        end

        while (n_trans < MAX_TRANS && vec_mem[COLS*n_trans] != END_MARK) begin
            run_transaction(n_trans);
            n_trans++;
        end

        repeat (3) @(posedge clk);  // Room for a stray extra response.
        if (n_trans == 0) begin
            $display("No transactions were read from the test data file");
            error_count++;
        end
        if (resp_count != n_trans) begin
            $display("Expected %0d responses but saw %0d", n_trans, resp_count);
            error_count++;
        end

        $display("Transactions: %0d, errors: %0d", n_trans, error_count + hold_errors);
        if (error_count + hold_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/plic_testdata.hex ====
// opcode address wdata int_i expected_rdata expected_eip, all hex
// One transaction per line; opcode f ends the list.
0 000004 00000000 00 00000000 0
0 002100 00000000 00 00000000 0
0 203000 00000000 00 00000000 0
0 203004 00000000 00 00000000 0
1 00001c ffffffff 00 00000000 0
0 00001c 00000000 00 00000001 0
1 002000 000000ff 00 00000000 0
0 002000 00000000 00 000000fe 0
1 201000 00000003 00 00000000 0
0 201000 00000000 00 00000001 0
1 000000 000000ff 00 00000000 0
0 000000 00000000 00 00000000 0
0 200008 00000000 00 00000000 0
1 002080 0000003c 00 00000000 0
6 002080 000000a5 00 0000003c 0
4 002080 0000000f 00 000000a4 0
5 002080 000000f1 00 00000004 0
7 002080 0000003c 00 000000f4 0
0 002080 00000000 00 000000c8 0
7 00000c 00000001 00 00000000 0
0 00000c 00000000 00 00000001 0
// Claim and complete on context 0, then context 1.
0 001000 00000000 55 000000aa 1
0 200004 00000000 55 00000007 1
0 200004 00000000 55 00000003 0
0 200004 00000000 55 00000000 0
1 200004 00000005 55 00000000 0
1 200004 00000007 55 00000000 1
0 200004 00000000 55 00000007 0
1 200004 00000003 55 00000000 1
1 200004 00000007 55 00000003 1
0 201004 00000000 55 00000007 1
1 201000 00000000 55 00000001 3
1 201004 00000007 55 00000003 3
1 002100 00000008 55 00000000 7
1 202000 00000001 55 00000000 3
5 002180 000000ff 55 00000000 b
0 001000 00000000 04 00000008 b
0 001000 00000000 40 00000080 b
1 00001c 00000000 40 00000001 0
0 00001c 00000000 00 00000000 0
0 203004 00000000 7f 00000003 3
0 203004 00000000 7f 00000000 3
1 203004 00000003 7f 00000000 b
f 000000 00000000 00 00000000 0
